// File: src/ru_pkg.sv
// boot table is fixed at four writes (2-bit step) and targets the update block's param codes
`default_nettype none

package ru_pkg;

	// ========================================
	// control codes on user_ctrl
	// ========================================
	typedef enum logic [2:0] {
		ctrl_nop      = 3'b000, // idle, required between strobes
		ctrl_read     = 3'b001, // read strobe on rise from nop
		ctrl_write    = 3'b010, // write strobe on rise from nop
		ctrl_reset    = 3'b100, // held level
		ctrl_abort    = 3'b101, // only meaningful during boot window
		ctrl_reconfig = 3'b111  // held level
	} ru_ctrl_t;

	typedef logic [2:0]  ru_param_t; // param select
	typedef logic [31:0] ru_word_t;  // data word to/from block

	// boot sequencer states
	typedef enum logic [2:0] {
		st_init       = 3'd0, // abort window, block held in reset
		st_load       = 3'd1,
		st_strobe_hi  = 3'd2, // selects write code
		st_strobe_lo  = 3'd3,
		st_busy_wait  = 3'd4, // until busy_fall
		st_done_check = 3'd5,
		st_reconfig   = 3'd6, // absorbing
		st_user       = 3'd7  // absorbing
	} ru_state_t;

	typedef logic [1:0] ru_step_t;

	// ========================================
	// boot table, indexed by step
	// ========================================
	localparam int RU_BOOT_STEPS = 4;

	localparam ru_param_t RU_BOOT_PARAM [RU_BOOT_STEPS] = '{
		3'd5, // config mode
		3'd4, // boot page address
		3'd2, // watchdog timeout
		3'd3  // watchdog enable
	};

	localparam ru_word_t RU_BOOT_DATA [RU_BOOT_STEPS] = '{
		32'h0000_0001, // application mode
		32'h0200_0000, // image base in flash
		32'h0000_1FFF,
		32'h0000_0001
	};

endpackage

`default_nettype wire

// File: src/ru_boot_timer.sv
// window counter needs clog2(BOOT_WAIT_CYCLES+1) bits; kick period is 2^KICK_BITS cycles
`timescale 1ns/10ps
`default_nettype none

module ru_boot_timer #(
	parameter int BOOT_WAIT_CYCLES = 125_000_000,
	parameter int KICK_BITS        = 8
) (
	input  wire logic clock_rd2,
	input  wire logic arst_n,
	input  wire logic in_init,     // from fsm, high only in init
	output logic      window_done,
	output logic      kick         // watchdog reset_timer
);

	localparam int CNT_W = $clog2(BOOT_WAIT_CYCLES + 1);

	logic [CNT_W-1:0]     win_cnt;
	logic [KICK_BITS-1:0] kick_cnt;

	// ========================================
	// abort window
	// ========================================
	assign window_done = (win_cnt == CNT_W'(BOOT_WAIT_CYCLES)); // saturated

	always_ff @(posedge clock_rd2 or negedge arst_n) begin
		if (!arst_n) begin
			win_cnt <= '0;
		end else if (in_init && !window_done) begin
			win_cnt <= win_cnt + 1'b1;
		end
	end

	// free running, top bit is the kick
	always_ff @(posedge clock_rd2 or negedge arst_n) begin
		if (!arst_n) begin
			kick_cnt <= '0;
		end else begin
			kick_cnt <= kick_cnt + 1'b1;
		end
	end

	assign kick = kick_cnt[KICK_BITS-1];

	// window must not reopen while fsm still sits in init
	a_window_held: assert property (@(posedge clock_rd2) disable iff (!arst_n)
		(window_done && in_init) |=> window_done);

endmodule

`default_nettype wire

// File: src/ru_boot_fsm.sv
// user_ctrl is sampled asynchronously through two flops; only the abort code is acted on here
`timescale 1ns/10ps
`default_nettype none

module ru_boot_fsm (
	input  wire logic              clock_rd2,
	input  wire logic              arst_n,
	input  wire ru_pkg::ru_ctrl_t  user_ctrl,
	input  wire logic              window_done, // from timer
	input  wire logic              busy_fall,   // registered, from readback
	output ru_pkg::ru_state_t      state,
	output ru_pkg::ru_step_t       step,
	output logic                   in_init
);

	import ru_pkg::*;

	ru_ctrl_t  ctrl_s1, ctrl_s2; // abort sync
	ru_state_t state_nxt;
	logic      last_step;

	always_ff @(posedge clock_rd2 or negedge arst_n) begin
		if (!arst_n) begin
			ctrl_s1 <= ctrl_nop;
			ctrl_s2 <= ctrl_nop;
		end else begin
			ctrl_s1 <= user_ctrl;
			ctrl_s2 <= ctrl_s1;
		end
	end

	assign last_step = (step == ru_step_t'(RU_BOOT_STEPS - 1));
	assign in_init   = (state == st_init);

	// ========================================
	// next state
	// ========================================
	always_comb begin
		state_nxt = state;
		case (state)
			st_init: begin
				if (ctrl_s2 == ctrl_abort) begin
					state_nxt = st_user; // abort wins over window end
				end else if (window_done) begin
					state_nxt = st_load;
				end
			end
			st_load:       state_nxt = st_strobe_hi;
			st_strobe_hi:  state_nxt = st_strobe_lo;
			st_strobe_lo:  state_nxt = st_busy_wait;
			st_busy_wait: begin
				// strobe may not have reached busy yet, so only an actual fall counts
				if (busy_fall) begin
					state_nxt = st_done_check;
				end
			end
			st_done_check: state_nxt = last_step ? st_reconfig : st_load;
			st_reconfig:   state_nxt = st_reconfig;
			st_user:       state_nxt = st_user;
			default:       state_nxt = st_init;
		endcase
	end

	always_ff @(posedge clock_rd2 or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_init;
			step  <= '0;
		end else begin
			state <= state_nxt;
			if (state == st_done_check && !last_step) begin
				step <= step + 1'b1; // next table entry
			end
		end
	end

	// once reconfig or user is reached nothing leaves it
	a_absorbing: assert property (@(posedge clock_rd2) disable iff (!arst_n)
		(state inside {st_reconfig, st_user}) |=> (state == $past(state)));

endmodule

`default_nettype wire

// File: src/ru_cmd_path.sv
// read/write strobe only on a step from nop, so the user must return to nop between commands
`timescale 1ns/10ps
`default_nettype none

module ru_cmd_path (
	input  wire logic               clock_rd2,
	input  wire logic               arst_n,
	input  wire ru_pkg::ru_state_t  state,
	input  wire ru_pkg::ru_step_t   step,
	input  wire ru_pkg::ru_ctrl_t   user_ctrl,
	input  wire ru_pkg::ru_param_t  user_param,
	input  wire ru_pkg::ru_word_t   user_data,
	output logic                    ip_reset,
	output logic                    ip_read_param,
	output logic                    ip_write_param,
	output logic                    ip_reconfig,
	output ru_pkg::ru_param_t       ip_param,
	output ru_pkg::ru_word_t        ip_data_in
);

	import ru_pkg::*;

	ru_ctrl_t  auto_ctrl, sel_ctrl;
	ru_param_t sel_param;
	ru_word_t  sel_data;
	ru_ctrl_t  ctrl_q, ctrl_last;

	// ========================================
	// auto vs user select
	// ========================================
	always_comb begin
		case (state)
			st_init:      auto_ctrl = ctrl_reset;
			st_strobe_hi: auto_ctrl = ctrl_write;
			st_reconfig:  auto_ctrl = ctrl_reconfig;
			default:      auto_ctrl = ctrl_nop;
		endcase
	end

	assign sel_ctrl  = (state == st_user) ? user_ctrl  : auto_ctrl;
	assign sel_param = (state == st_user) ? user_param : RU_BOOT_PARAM[step];
	assign sel_data  = (state == st_user) ? user_data  : RU_BOOT_DATA[step];

	// payload, no reset
	always_ff @(posedge clock_rd2) begin
		ip_param   <= sel_param;
		ip_data_in <= sel_data;
	end

	always_ff @(posedge clock_rd2 or negedge arst_n) begin
		if (!arst_n) begin
			ctrl_q    <= ctrl_nop;
			ctrl_last <= ctrl_nop;
		end else begin
			ctrl_q    <= sel_ctrl;
			ctrl_last <= ctrl_q; // previous code, for edge detect
		end
	end

	// ========================================
	// decode, one cycle behind ctrl_q
	// ========================================
	always_ff @(posedge clock_rd2 or negedge arst_n) begin
		if (!arst_n) begin
			ip_reset       <= 1'b0;
			ip_read_param  <= 1'b0;
			ip_write_param <= 1'b0;
			ip_reconfig    <= 1'b0;
		end else begin
			ip_reset       <= (ctrl_q == ctrl_reset);    // level
			ip_reconfig    <= (ctrl_q == ctrl_reconfig); // level
			ip_read_param  <= (ctrl_q == ctrl_read)  && (ctrl_last == ctrl_nop);
			ip_write_param <= (ctrl_q == ctrl_write) && (ctrl_last == ctrl_nop);
		end
	end

	// block expects single cycle strobes
	a_rd_single: assert property (@(posedge clock_rd2) disable iff (!arst_n)
		ip_read_param |=> !ip_read_param);
	a_wr_single: assert property (@(posedge clock_rd2) disable iff (!arst_n)
		ip_write_param |=> !ip_write_param);

endmodule

`default_nettype wire

// File: src/ru_readback.sv
// assumes ip_data_out is stable from busy falling until the next operation starts
`timescale 1ns/10ps
`default_nettype none

module ru_readback (
	input  wire logic              clock_rd2,
	input  wire logic              arst_n,
	input  wire logic              ip_busy,
	input  wire ru_pkg::ru_word_t  ip_data_out,
	output logic                   busy_fall,  // one cycle pulse
	output ru_pkg::ru_word_t       read_data
);

	logic [2:0] busy_sr; // [1:0] sync, [2] previous synced sample
	logic       fall_det;

	always_ff @(posedge clock_rd2 or negedge arst_n) begin
		if (!arst_n) begin
			busy_sr <= 3'b000;
		end else begin
			busy_sr <= {busy_sr[1:0], ip_busy};
		end
	end

	assign fall_det = busy_sr[2] & ~busy_sr[1]; // synced 1 -> 0

	// ========================================
	// edge pulse and capture
	// ========================================
	always_ff @(posedge clock_rd2 or negedge arst_n) begin
		if (!arst_n) begin
			busy_fall <= 1'b0;
			read_data <= '0;
		end else begin
			busy_fall <= fall_det;
			if (fall_det) begin
				read_data <= ip_data_out; // holds until next fall
			end
		end
	end

endmodule

`default_nettype wire

// File: src/ru_update_top.sv
// clock_rd2 must meet the update block's clock limit; BOOT_WAIT_CYCLES is in clock_rd2 cycles
`timescale 1ns/10ps
`default_nettype none

module ru_update_top #(
	parameter int BOOT_WAIT_CYCLES = 125_000_000, // abort window
	parameter int KICK_BITS        = 8
) (
	input  wire logic               clock_rd2,
	input  wire logic               arst_n,
	// user side
	input  wire ru_pkg::ru_ctrl_t   user_ctrl,
	input  wire ru_pkg::ru_param_t  user_param,
	input  wire ru_pkg::ru_word_t   user_data,
	output ru_pkg::ru_word_t        read_data,
	// update block side
	output logic                    ip_reset,
	output logic                    ip_read_param,
	output logic                    ip_write_param,
	output logic                    ip_reconfig,
	output ru_pkg::ru_param_t       ip_param,
	output ru_pkg::ru_word_t        ip_data_in,
	output logic                    ip_reset_timer,
	input  wire logic               ip_busy,
	input  wire ru_pkg::ru_word_t   ip_data_out
);

	import ru_pkg::*;

	logic      window_done;
	logic      in_init;
	logic      busy_fall;
	ru_state_t state;
	ru_step_t  step;

	// ========================================
	// sequencing
	// ========================================
	ru_boot_timer #(
		.BOOT_WAIT_CYCLES (BOOT_WAIT_CYCLES),
		.KICK_BITS        (KICK_BITS)
	) timer_i (
		.clock_rd2   (clock_rd2),
		.arst_n      (arst_n),
		.in_init     (in_init),
		.window_done (window_done),
		.kick        (ip_reset_timer) // watchdog kick straight out
	);

	ru_boot_fsm fsm_i (
		.clock_rd2   (clock_rd2),
		.arst_n      (arst_n),
		.user_ctrl   (user_ctrl),
		.window_done (window_done),
		.busy_fall   (busy_fall),
		.state       (state),
		.step        (step),
		.in_init     (in_init)
	);

	// ========================================
	// block interface
	// ========================================
	ru_cmd_path cmd_i (
		.clock_rd2      (clock_rd2),
		.arst_n         (arst_n),
		.state          (state),
		.step           (step),
		.user_ctrl      (user_ctrl),
		.user_param     (user_param),
		.user_data      (user_data),
		.ip_reset       (ip_reset),
		.ip_read_param  (ip_read_param),
		.ip_write_param (ip_write_param),
		.ip_reconfig    (ip_reconfig),
		.ip_param       (ip_param),
		.ip_data_in     (ip_data_in)
	);

	ru_readback rdbk_i (
		.clock_rd2   (clock_rd2),
		.arst_n      (arst_n),
		.ip_busy     (ip_busy),
		.ip_data_out (ip_data_out),
		.busy_fall   (busy_fall),
		.read_data   (read_data)
	);

endmodule

`default_nettype wire

// File: sim/ru_ip_model.sv
// busy length is 3 to 6 cycles from an internal LCG; memory keeps its contents across reset
`timescale 1ns/10ps
`default_nettype none

module ru_ip_model #(
	parameter logic [31:0] SEED = 32'hb0b3_1e9b
) (
	input  wire logic              clock_rd2,
	input  wire logic              arst_n,
	input  wire logic              read_param,  // single cycle strobes from dut
	input  wire logic              write_param,
	input  wire ru_pkg::ru_param_t param,
	input  wire ru_pkg::ru_word_t  data_in,
	output logic                   busy,
	output ru_pkg::ru_word_t       data_out     // only changes on a read
);

	import ru_pkg::*;

	ru_word_t    mem [8];
	logic [31:0] lcg;
	logic [2:0]  busy_left;

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	initial begin
		for (int i = 0; i < 8; i++) begin
			mem[i] = 32'h5eed_0000 | (i * 32'h0001_0111); // every address bit shows
		end
	end

	always @(posedge clock_rd2 or negedge arst_n) begin
		if (!arst_n) begin
			busy      <= 1'b0;
			busy_left <= '0;
			data_out  <= '0;
			lcg       <= SEED;
		end else if (read_param || write_param) begin
			busy      <= 1'b1;
			busy_left <= 3'd2 + lcg[17:16]; // high for 3..6 cycles
			lcg       <= lcg_step(lcg);
			if (write_param)
				mem[param] <= data_in;
			else
				data_out <= mem[param]; // valid by the busy fall
		end else if (busy) begin
			if (busy_left == 0)
				busy <= 1'b0;
			else
				busy_left <= busy_left - 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: sim/tb_ru_update.sv
// window cut to 40 cycles and kick to 4 bits; user param/data are held until the next command
`timescale 1ns/10ps
`default_nettype none

module tb_ru_update;

	import ru_pkg::*;

	localparam int N_WRITES = 8;
	localparam int N_READS  = 6;

	logic      clock_rd2 = 1'b0;
	logic      arst_n;
	ru_ctrl_t  user_ctrl;
	ru_param_t user_param;
	ru_param_t ip_param;
	ru_word_t  user_data, read_data, ip_data_in, ip_data_out;
	logic      ip_reset, ip_read_param, ip_write_param, ip_reconfig;
	logic      ip_reset_timer, ip_busy;

	logic [31:0] rand_state = 32'hb0b3_1e9b;
	int          errors = 0;
	int          timeouts = 0;
	int          cycle = 0;
	int          last_toggle = 0;
	int          toggles = 0;
	logic        kick_prev = 1'b0;
	logic        kick_seen = 1'b0;
	logic        reconfig_seen = 1'b0;
	ru_word_t    last_read = '0; // block data_out is zero until the first read
	ru_param_t   obs_param [$]; // what the block received
	ru_word_t    obs_data [$];
	ru_param_t   exp_param [$];
	ru_word_t    exp_data [$];
	ru_word_t    ref_mem [8];   // mirror of the block's param store
	ru_param_t   boot_param [4] = '{3'd5, 3'd4, 3'd2, 3'd3};
	ru_word_t    boot_data [4]  = '{32'h0000_0001, 32'h0200_0000, 32'h0000_1fff, 32'h0000_0001};

	always #50 clock_rd2 = ~clock_rd2; // 100 ns period

	ru_update_top #(
		.BOOT_WAIT_CYCLES (40),
		.KICK_BITS        (4)
	) dut_i (
		.clock_rd2      (clock_rd2),
		.arst_n         (arst_n),
		.user_ctrl      (user_ctrl),
		.user_param     (user_param),
		.user_data      (user_data),
		.read_data      (read_data),
		.ip_reset       (ip_reset),
		.ip_read_param  (ip_read_param),
		.ip_write_param (ip_write_param),
		.ip_reconfig    (ip_reconfig),
		.ip_param       (ip_param),
		.ip_data_in     (ip_data_in),
		.ip_reset_timer (ip_reset_timer),
		.ip_busy        (ip_busy),
		.ip_data_out    (ip_data_out)
	);

	ru_ip_model ip_model_i (
		.clock_rd2   (clock_rd2),
		.arst_n      (arst_n),
		.read_param  (ip_read_param),
		.write_param (ip_write_param),
		.param       (ip_param),
		.data_in     (ip_data_in),
		.busy        (ip_busy),
		.data_out    (ip_data_out)
	);

	// ========================================
	// helpers and compare tasks
	// ========================================
	function automatic logic [31:0] next_rand();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	// block side outputs folded back into one command code
	function automatic ru_ctrl_t block_cmd();
		if (ip_reconfig) return ctrl_reconfig;
		if (ip_reset) return ctrl_reset;
		if (ip_write_param) return ctrl_write;
		if (ip_read_param) return ctrl_read;
		return ctrl_nop;
	endfunction

	task automatic check_ctrl(input string name, input ru_ctrl_t exp, input ru_ctrl_t act);
		if (act !== exp) begin
			errors++;
			$display("ERROR %s: expected %s, actual %s", name, exp.name(), act.name());
		end
	endtask

	task automatic check_param(input string name, input ru_param_t exp, input ru_param_t act);
		if (act !== exp) begin
			errors++;
			$display("ERROR %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_word(input string name, input ru_word_t exp, input ru_word_t act);
		if (act !== exp) begin
			errors++;
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			errors++;
			$display("ERROR %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic apply_reset();
		@(posedge clock_rd2);
		arst_n <= 1'b0;
		@(posedge clock_rd2);
		obs_param.delete(); // monitor is quiet while reset is low
		obs_data.delete();
		reconfig_seen = 1'b0;
		repeat (4) @(posedge clock_rd2);
		arst_n <= 1'b1;
	endtask

	// busy up, busy down, then sync and capture in readback
	task automatic wait_busy_cycle(input string what, input ru_word_t hold);
		int n;
		n = 0;
		while (ip_busy !== 1'b1 && n < 20) begin
			@(posedge clock_rd2);
			n++;
		end
		if (ip_busy !== 1'b1) begin
			timeouts++;
			$display("TIMEOUT: busy never rose during %s", what);
		end
		n = 0;
		while (ip_busy !== 1'b0 && n < 20) begin
			// old capture must survive until this fall
			check_word($sformatf("%s read data held", what), hold, read_data);
			@(posedge clock_rd2);
			n++;
		end
		if (ip_busy !== 1'b0) begin
			timeouts++;
			$display("TIMEOUT: busy never fell during %s", what);
		end
		repeat (4) @(posedge clock_rd2); // 2 sync flops + edge + capture
	endtask

	// monitor samples pre-edge values
	always @(posedge clock_rd2) begin
		cycle++;
		if (!arst_n) begin
			kick_seen = 1'b0;
		end else begin
			if (ip_write_param) begin
				obs_param.push_back(ip_param);
				obs_data.push_back(ip_data_in);
			end
			if (ip_reconfig)
				reconfig_seen = 1'b1;
			if (ip_reset_timer !== kick_prev) begin
				if (kick_seen)
					check_count("kick interval", 8, cycle - last_toggle); // 2^(4-1)
				kick_seen   = 1'b1;
				last_toggle = cycle;
				toggles++;
			end
		end
		kick_prev = ip_reset_timer;
	end

	// ========================================
	// stimulus
	// ========================================
	initial begin
		ru_param_t p;
		ru_word_t  d;
		int        n;
		arst_n     = 1'b0;
		user_ctrl  = ctrl_nop;
		user_param = '0;
		user_data  = '0;
		for (int i = 0; i < 8; i++) begin
			ref_mem[i] = 32'h5eed_0000 | (i * 32'h0001_0111); // same fill as the block
		end

		// auto boot without abort
		apply_reset();
		repeat (3) @(posedge clock_rd2);
		check_ctrl("init holds block in reset", ctrl_reset, block_cmd());
		n = 0;
		while (ip_reconfig !== 1'b1 && n < 500) begin
			@(posedge clock_rd2);
			n++;
		end
		if (ip_reconfig !== 1'b1) begin
			timeouts++;
			$display("TIMEOUT: reconfig never rose after auto boot");
		end
		check_count("boot write count", 4, obs_param.size());
		for (int i = 0; i < 4; i++) begin
			ref_mem[boot_param[i]] = boot_data[i];
			if (i < obs_param.size()) begin
				check_param($sformatf("boot step %0d param", i), boot_param[i], obs_param[i]);
				check_word($sformatf("boot step %0d data", i), boot_data[i], obs_data[i]);
			end
		end
		repeat (20) begin
			@(posedge clock_rd2);
			check_ctrl("reconfig held", ctrl_reconfig, block_cmd());
		end

		// abort inside the window
		apply_reset();
		repeat (3) @(posedge clock_rd2);
		user_ctrl <= ctrl_abort;
		n = 0;
		while (ip_reset !== 1'b0 && n < 20) begin
			@(posedge clock_rd2);
			n++;
		end
		if (ip_reset !== 1'b0) begin
			timeouts++;
			$display("TIMEOUT: block reset never released after abort");
		end
		repeat (60) @(posedge clock_rd2); // well past the 40 cycle window
		check_count("auto writes after abort", 0, obs_param.size());
		if (reconfig_seen) begin
			errors++;
			$display("reconfig was asserted although boot was aborted");
		end
		user_ctrl <= ctrl_nop;
		repeat (4) @(posedge clock_rd2);
		check_ctrl("user mode idle", ctrl_nop, block_cmd());

		// user writes with the write code held 1..3 cycles
		for (int i = 0; i < N_WRITES; i++) begin
			p = ru_param_t'(next_rand());
			d = next_rand();
			n = 1 + int'(next_rand() % 3);
			exp_param.push_back(p);
			exp_data.push_back(d);
			ref_mem[p] = d;
			@(posedge clock_rd2);
			user_param <= p;
			user_data  <= d;
			user_ctrl  <= ctrl_write;
			repeat (n) @(posedge clock_rd2);
			user_ctrl <= ctrl_nop;
			wait_busy_cycle("user write", last_read);
		end
		check_count("user write strobes", N_WRITES, obs_param.size());
		for (int i = 0; i < N_WRITES && i < obs_param.size(); i++) begin
			check_param($sformatf("user write %0d param", i), exp_param[i], obs_param[i]);
			check_word($sformatf("user write %0d data", i), exp_data[i], obs_data[i]);
		end

		// user reads against the mirror
		for (int i = 0; i < N_READS; i++) begin
			p = ru_param_t'(next_rand());
			@(posedge clock_rd2);
			user_param <= p;
			user_ctrl  <= ctrl_read;
			@(posedge clock_rd2);
			user_ctrl <= ctrl_nop;
			wait_busy_cycle("user read", last_read);
			check_word($sformatf("read param %0d", p), ref_mem[p], read_data);
			last_read = ref_mem[p];
		end

		if (toggles < 4) begin
			errors++;
			$display("watchdog kick barely toggled, only %0d edges seen", toggles);
		end

		$display("checks done: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: ru_update.f
src/ru_pkg.sv
src/ru_boot_timer.sv
src/ru_boot_fsm.sv
src/ru_cmd_path.sv
src/ru_readback.sv
src/ru_update_top.sv
sim/ru_ip_model.sv
sim/tb_ru_update.sv
